// File: verilog/rvCorePkg.sv
package rvCorePkg;

  // ======================================================================
  // widths and base types
  // ======================================================================

  localparam int xlen    = 32;
  localparam int regIdxW = 5;

  typedef logic [xlen-1:0]    word_t;
  typedef logic [regIdxW-1:0] regIdx_t;
  // {alternate bit, funct3}
  typedef logic [3:0]         aluOp_t;
  typedef logic [3:0]         byteEn_t;
  typedef logic [4:0]         opcode_t;
  typedef logic [2:0]         funct3_t;

  // access size, same coding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    memByte = 2'd0,
    memHalf = 2'd1,
    memWord = 2'd2
  } memSize_t;

  // ======================================================================
  // opcodes, instr[6:2] since the low two bits are always 11
  // ======================================================================

  localparam opcode_t opLoad  = 5'b00000;
  localparam opcode_t opOpImm = 5'b00100;
  localparam opcode_t opAuipc = 5'b00101;
  localparam opcode_t opStore = 5'b01000;
  localparam opcode_t opOp    = 5'b01100;
  localparam opcode_t opLui   = 5'b01101;

  // alu funct3, shared by op and op-imm
  localparam funct3_t f3AddSub = 3'b000;
  localparam funct3_t f3Sll    = 3'b001;
  localparam funct3_t f3Slt    = 3'b010;
  localparam funct3_t f3Sltu   = 3'b011;
  localparam funct3_t f3Xor    = 3'b100;
  localparam funct3_t f3SrlSra = 3'b101;
  localparam funct3_t f3Or     = 3'b110;
  localparam funct3_t f3And    = 3'b111;

  // ======================================================================
  // stage payloads
  // ======================================================================

  // decode to operand stage
  typedef struct packed {
    logic     valid;
    word_t    pc;
    regIdx_t  rs1;
    regIdx_t  rs2;
    regIdx_t  rd;
    logic     rdWe;
    logic     useRs1;
    logic     useRs2;
    logic     immSel;
    word_t    imm;
    aluOp_t   aluOp;
    logic     isLoad;
    logic     isStore;
    logic     isLui;
    logic     isAuipc;
    memSize_t size;
    logic     unsignedLoad;
  } decodedInstr_t;

  // operand stage to execute
  typedef struct packed {
    logic     valid;
    regIdx_t  rd;
    logic     rdWe;
    aluOp_t   aluOp;
    word_t    aluIn1;
    word_t    aluIn2;
    logic     isLoad;
    logic     isStore;
    word_t    memAddr;
    word_t    storeData;
    memSize_t size;
    logic     unsignedLoad;
  } execInstr_t;

endpackage

// File: verilog/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit #(
  parameter rvCorePkg::word_t resetPc = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             stall,
  input  logic             refetch,
  input  rvCorePkg::word_t refetchPc,
  input  logic             ibusWait,
  output rvCorePkg::word_t ibusAddr,
  output logic             ibusRead
);

  rvCorePkg::word_t pc;
  // keeps the read low in the first cycle out of reset
  logic started;

  assign ibusAddr = pc;

  // read every cycle the front end is free
  assign ibusRead = started && !stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= resetPc;
      started <= 1'b0;
    end else begin
      started <= 1'b1;
      // refetch only comes while stalled, so no read is in progress
      if (refetch) begin
        pc <= refetchPc;
      end else if (ibusRead && !ibusWait) begin
        // read taken, move to the next word
        pc <= pc + 32'd4;
      end
      // otherwise hold the address through wait or stall
    end
  end

  // ======================================================================
  // checks
  // ======================================================================

  // reset value and refetch target from decode must both keep alignment
  pcAligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    ibusAddr[1:0] == 2'b00
  );

endmodule

// File: verilog/decodeUnit.sv
`timescale 1ns/10ps

module decodeUnit #(
  parameter rvCorePkg::word_t resetPc = '0
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stall,
  input  rvCorePkg::word_t         ibusData,
  input  rvCorePkg::word_t         ibusIAddr,
  input  logic                     ibusValid,
  output rvCorePkg::decodedInstr_t decoded,
  output logic                     refetch,
  output rvCorePkg::word_t         refetchPc
);

  // address of the next word decode is waiting for
  rvCorePkg::word_t expPc;
  logic match;
  rvCorePkg::opcode_t opcode;
  rvCorePkg::funct3_t funct3;
  rvCorePkg::decodedInstr_t decodeNext;

  assign opcode = ibusData[6:2];
  assign funct3 = ibusData[14:12];

  // words from the wrong address are dropped
  assign match = ibusValid && (ibusIAddr == expPc);

  // a good word lost to a stall has to be read again
  assign refetch   = match && stall;
  assign refetchPc = expPc;

  // ======================================================================
  // field decode
  // ======================================================================

  always_comb begin
    decodeNext              = '0;
    decodeNext.pc           = ibusIAddr;
    decodeNext.rs1          = ibusData[19:15];
    decodeNext.rs2          = ibusData[24:20];
    decodeNext.rd           = ibusData[11:7];
    decodeNext.unsignedLoad = funct3[2];
    // loads, stores and upper immediates all go through add
    decodeNext.aluOp        = {1'b0, rvCorePkg::f3AddSub};

    case (funct3[1:0])
      2'b00:   decodeNext.size = rvCorePkg::memByte;
      2'b01:   decodeNext.size = rvCorePkg::memHalf;
      default: decodeNext.size = rvCorePkg::memWord;
    endcase

    case (opcode)
      rvCorePkg::opOp: begin
        decodeNext.valid  = 1'b1;
        decodeNext.rdWe   = 1'b1;
        decodeNext.useRs1 = 1'b1;
        decodeNext.useRs2 = 1'b1;
        // bit 30 picks sub and sra
        decodeNext.aluOp  = {ibusData[30], funct3};
      end
      rvCorePkg::opOpImm: begin
        decodeNext.valid  = 1'b1;
        decodeNext.rdWe   = 1'b1;
        decodeNext.useRs1 = 1'b1;
        decodeNext.immSel = 1'b1;
        decodeNext.imm    = {{20{ibusData[31]}}, ibusData[31:20]};
        // no subi, bit 30 is only an opcode bit for srai
        decodeNext.aluOp  = {(funct3 == rvCorePkg::f3SrlSra) && ibusData[30], funct3};
      end
      rvCorePkg::opLoad: begin
        decodeNext.valid  = 1'b1;
        decodeNext.rdWe   = 1'b1;
        decodeNext.useRs1 = 1'b1;
        decodeNext.immSel = 1'b1;
        decodeNext.isLoad = 1'b1;
        decodeNext.imm    = {{20{ibusData[31]}}, ibusData[31:20]};
      end
      rvCorePkg::opStore: begin
        decodeNext.valid   = 1'b1;
        decodeNext.useRs1  = 1'b1;
        decodeNext.useRs2  = 1'b1;
        decodeNext.immSel  = 1'b1;
        decodeNext.isStore = 1'b1;
        // s-type splits the offset around rd
        decodeNext.imm     = {{20{ibusData[31]}}, ibusData[31:25], ibusData[11:7]};
      end
      rvCorePkg::opLui, rvCorePkg::opAuipc: begin
        decodeNext.valid   = 1'b1;
        decodeNext.rdWe    = 1'b1;
        decodeNext.immSel  = 1'b1;
        decodeNext.isLui   = (opcode == rvCorePkg::opLui);
        decodeNext.isAuipc = (opcode == rvCorePkg::opAuipc);
        decodeNext.imm     = {ibusData[31:12], 12'b0};
      end
      default: begin
        // anything else leaves a bubble
        decodeNext.valid = 1'b0;
      end
    endcase

    // x0 writes are dropped here, so x0 never goes pending
    if (decodeNext.rd == '0) begin
      decodeNext.rdWe = 1'b0;
    end
    decodeNext.valid = decodeNext.valid && match && (ibusData[1:0] == 2'b11);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      decoded <= '0;
      expPc   <= resetPc;
    end else if (!stall) begin
      decoded <= decodeNext;
      if (match) begin
        expPc <= expPc + 32'd4;
      end
    end
  end

endmodule

// File: verilog/operandStage.sv
`timescale 1ns/10ps

module operandStage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     memStall,
  input  rvCorePkg::decodedInstr_t decoded,
  input  logic                     wbValid,
  input  rvCorePkg::regIdx_t       wbRd,
  input  rvCorePkg::word_t         wbData,
  output logic                     hazard,
  output rvCorePkg::execInstr_t    exec
);

  localparam int numRegs = 2 ** rvCorePkg::regIdxW;

  rvCorePkg::word_t regFile [numRegs];
  // one bit per register with a result still in flight
  logic [numRegs-1:0] pending;
  logic [numRegs-1:0] pendingNext;
  rvCorePkg::word_t rs1Val;
  rvCorePkg::word_t rs2Val;
  logic rs1Busy;
  logic rs2Busy;
  logic rdBusy;
  logic issue;
  rvCorePkg::execInstr_t execNext;

  // read with bypass from the write back of this cycle
  function automatic rvCorePkg::word_t readSrc(input rvCorePkg::regIdx_t idx);
    rvCorePkg::word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wbValid && (wbRd == idx)) begin
      val = wbData;
    end else begin
      val = regFile[idx];
    end
    return val;
  endfunction

  // a bit cleared in this cycle no longer blocks
  function automatic logic isBusy(input rvCorePkg::regIdx_t idx);
    return pending[idx] && !(wbValid && (wbRd == idx));
  endfunction

  // ======================================================================
  // register file and scoreboard
  // ======================================================================

  always_ff @(posedge clk) begin
    if (wbValid) begin
      regFile[wbRd] <= wbData;
    end
  end

  assign rs1Busy = decoded.useRs1 && isBusy(decoded.rs1);
  assign rs2Busy = decoded.useRs2 && isBusy(decoded.rs2);
  // one writer per register at a time
  assign rdBusy  = decoded.rdWe && isBusy(decoded.rd);

  assign hazard = decoded.valid && (rs1Busy || rs2Busy || rdBusy);
  assign issue  = decoded.valid && !hazard && !memStall;

  always_comb begin
    pendingNext = pending;
    // write back clears even while the pipe is frozen
    if (wbValid) begin
      pendingNext[wbRd] = 1'b0;
    end
    // new owner wins over a clear of the same bit
    if (issue && decoded.rdWe) begin
      pendingNext[decoded.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pendingNext;
    end
  end

  // ======================================================================
  // operand select
  // ======================================================================

  always_comb begin
    rs1Val = readSrc(decoded.rs1);
    rs2Val = readSrc(decoded.rs2);

    execNext              = '0;
    // bubble forward on a hazard
    execNext.valid        = decoded.valid && !hazard;
    execNext.rd           = decoded.rd;
    execNext.rdWe         = decoded.rdWe;
    execNext.aluOp        = decoded.aluOp;
    execNext.isLoad       = decoded.isLoad;
    execNext.isStore      = decoded.isStore;
    execNext.size         = decoded.size;
    execNext.unsignedLoad = decoded.unsignedLoad;
    // auipc adds to pc, lui adds to zero
    if (decoded.isAuipc) begin
      execNext.aluIn1 = decoded.pc;
    end else if (decoded.isLui) begin
      execNext.aluIn1 = '0;
    end else begin
      execNext.aluIn1 = rs1Val;
    end
    execNext.aluIn2    = decoded.immSel ? decoded.imm : rs2Val;
    execNext.memAddr   = rs1Val + decoded.imm;
    execNext.storeData = rs2Val;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exec <= '0;
    end else if (!memStall) begin
      exec <= execNext;
    end
  end

  // decode must never hand over an x0 destination as written
  x0NeverPending: assert property (
    @(posedge clk) disable iff (!rst_n)
    !pending[0]
  );

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rvCorePkg::execInstr_t exec,
  input  rvCorePkg::word_t      dbusRdata,
  input  logic                  dbusWait,
  output rvCorePkg::word_t      dbusAddr,
  output logic                  dbusRead,
  output logic                  dbusWe,
  output rvCorePkg::word_t      dbusData,
  output rvCorePkg::byteEn_t    dbusByteEn,
  output logic                  memStall,
  output logic                  wbValid,
  output rvCorePkg::regIdx_t    wbRd,
  output rvCorePkg::word_t      wbData
);

  rvCorePkg::word_t aluRes;
  rvCorePkg::word_t loadRes;
  logic [4:0] shamt;

  // ======================================================================
  // alu
  // ======================================================================

  assign shamt = exec.aluIn2[4:0];

  always_comb begin
    case (exec.aluOp[2:0])
      rvCorePkg::f3AddSub: begin
        aluRes = exec.aluOp[3] ? exec.aluIn1 - exec.aluIn2 : exec.aluIn1 + exec.aluIn2;
      end
      rvCorePkg::f3Sll:  aluRes = exec.aluIn1 << shamt;
      rvCorePkg::f3Slt:  aluRes = {31'b0, $signed(exec.aluIn1) < $signed(exec.aluIn2)};
      rvCorePkg::f3Sltu: aluRes = {31'b0, exec.aluIn1 < exec.aluIn2};
      rvCorePkg::f3Xor:  aluRes = exec.aluIn1 ^ exec.aluIn2;
      rvCorePkg::f3SrlSra: begin
        // arithmetic shift keeps the sign bit
        aluRes = exec.aluOp[3] ? $unsigned($signed(exec.aluIn1) >>> shamt)
                               : exec.aluIn1 >> shamt;
      end
      rvCorePkg::f3Or:   aluRes = exec.aluIn1 | exec.aluIn2;
      rvCorePkg::f3And:  aluRes = exec.aluIn1 & exec.aluIn2;
      default:           aluRes = '0;
    endcase
  end

  // ======================================================================
  // data bus
  // ======================================================================

  // sub-word data sits in the low lanes of the aligned word
  assign dbusAddr = {exec.memAddr[31:2], 2'b00};
  assign dbusRead = exec.valid && exec.isLoad;
  assign dbusWe   = exec.valid && exec.isStore;
  assign dbusData = exec.storeData;

  always_comb begin
    case (exec.size)
      rvCorePkg::memByte: dbusByteEn = 4'b0001;
      rvCorePkg::memHalf: dbusByteEn = 4'b0011;
      rvCorePkg::memWord: dbusByteEn = 4'b1111;
      default:            dbusByteEn = 4'b0000;
    endcase
  end

  // whole pipe waits for the access to finish
  assign memStall = (dbusRead || dbusWe) && dbusWait;

  // load extension, low lanes only
  always_comb begin
    case (exec.size)
      rvCorePkg::memByte: begin
        loadRes = exec.unsignedLoad ? {24'b0, dbusRdata[7:0]}
                                    : {{24{dbusRdata[7]}}, dbusRdata[7:0]};
      end
      rvCorePkg::memHalf: begin
        loadRes = exec.unsignedLoad ? {16'b0, dbusRdata[15:0]}
                                    : {{16{dbusRdata[15]}}, dbusRdata[15:0]};
      end
      default: loadRes = dbusRdata;
    endcase
  end

  // ======================================================================
  // write back register
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbValid <= 1'b0;
      wbRd    <= '0;
      wbData  <= '0;
    end else if (memStall) begin
      // previous result is already written, nothing new yet
      wbValid <= 1'b0;
    end else begin
      wbValid <= exec.valid && exec.rdWe;
      wbRd    <= exec.rd;
      // load data is sampled in the cycle wait drops
      wbData  <= exec.isLoad ? loadRes : aluRes;
    end
  end

  // load and store are exclusive from decode onwards
  busExclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(dbusRead && dbusWe)
  );

  // operand stage must hold the request while the bus waits
  busHeld: assert property (
    @(posedge clk) disable iff (!rst_n)
    memStall |=> $stable({dbusRead, dbusWe, dbusAddr, dbusData, dbusByteEn})
  );

endmodule

// File: verilog/rvCore.sv
`timescale 1ns/10ps

module rvCore #(
  parameter rvCorePkg::word_t resetPc = '0
) (
  input  logic               clk,
  input  logic               rst_n,
  // instruction bus
  output rvCorePkg::word_t   ibusAddr,
  output logic               ibusRead,
  input  rvCorePkg::word_t   ibusData,
  input  rvCorePkg::word_t   ibusIAddr,
  input  logic               ibusValid,
  input  logic               ibusWait,
  // data bus
  output rvCorePkg::word_t   dbusAddr,
  output rvCorePkg::word_t   dbusData,
  output logic               dbusRead,
  output logic               dbusWe,
  output rvCorePkg::byteEn_t dbusByteEn,
  input  rvCorePkg::word_t   dbusRdata,
  input  logic               dbusWait
);

  rvCorePkg::decodedInstr_t decoded;
  rvCorePkg::execInstr_t exec;
  logic hazard;
  logic memStall;
  // fetch and decode hold on either stall source
  logic frontStall;
  logic refetch;
  rvCorePkg::word_t refetchPc;
  logic wbValid;
  rvCorePkg::regIdx_t wbRd;
  rvCorePkg::word_t wbData;

  assign frontStall = hazard || memStall;

  fetchUnit #(
    .resetPc (resetPc)
  ) u_fetchUnit (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (frontStall),
    .refetch   (refetch),
    .refetchPc (refetchPc),
    .ibusWait  (ibusWait),
    .ibusAddr  (ibusAddr),
    .ibusRead  (ibusRead)
  );

  decodeUnit #(
    .resetPc (resetPc)
  ) u_decodeUnit (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (frontStall),
    .ibusData  (ibusData),
    .ibusIAddr (ibusIAddr),
    .ibusValid (ibusValid),
    .decoded   (decoded),
    .refetch   (refetch),
    .refetchPc (refetchPc)
  );

  operandStage u_operandStage (
    .clk      (clk),
    .rst_n    (rst_n),
    .memStall (memStall),
    .decoded  (decoded),
    .wbValid  (wbValid),
    .wbRd     (wbRd),
    .wbData   (wbData),
    .hazard   (hazard),
    .exec     (exec)
  );

  executeStage u_executeStage (
    .clk        (clk),
    .rst_n      (rst_n),
    .exec       (exec),
    .dbusRdata  (dbusRdata),
    .dbusWait   (dbusWait),
    .dbusAddr   (dbusAddr),
    .dbusRead   (dbusRead),
    .dbusWe     (dbusWe),
    .dbusData   (dbusData),
    .dbusByteEn (dbusByteEn),
    .memStall   (memStall),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .wbData     (wbData)
  );

endmodule

// File: tests/rvRefModel.svh
`ifndef RVREFMODEL_SVH
`define RVREFMODEL_SVH

// initial data memory word, spread over the whole word index
function automatic rvCorePkg::word_t fillWord(input int idx);
  return (32'(idx) * 32'h9e37_79b1) ^ 32'h1357_9bdf;
endfunction

// isa arithmetic on two operands
function automatic rvCorePkg::word_t aluRef(input logic [2:0] f3, input logic alt,
                                            input rvCorePkg::word_t a,
                                            input rvCorePkg::word_t b);
  rvCorePkg::word_t res;
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'd0: res = alt ? a - b : a + b;
    3'd1: res = a << sh;
    3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: res = (a < b) ? 32'd1 : 32'd0;
    3'd4: res = a ^ b;
    3'd5: begin
      res = a >> sh;
      // fill the vacated high bits with the sign
      if (alt && a[31]) begin
        res = res | ~(32'hffff_ffff >> sh);
      end
    end
    3'd6: res = a | b;
    default: res = a & b;
  endcase
  return res;
endfunction

// in-order run of the program, collecting every store
function automatic void runReference();
  rvCorePkg::word_t regs [32];
  rvCorePkg::word_t mem [64];
  rvCorePkg::word_t ins;
  rvCorePkg::word_t pc;
  rvCorePkg::word_t immI;
  rvCorePkg::word_t immS;
  rvCorePkg::word_t addr;
  rvCorePkg::word_t w;
  rvCorePkg::word_t res;
  rvCorePkg::byteEn_t be;
  logic [2:0] f3;
  logic wr;
  int base;
  base = int'(resetPc[10:2]);
  for (int k = 0; k < 64; k++) begin
    mem[k] = fillWord(k);
  end
  for (int k = 0; k < 32; k++) begin
    regs[k] = '0;
  end
  for (int i = 0; i < progLen; i++) begin
    ins  = imem[base + i];
    pc   = resetPc + 32'(4 * i);
    f3   = ins[14:12];
    immI = {{20{ins[31]}}, ins[31:20]};
    immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    wr   = 1'b1;
    res  = '0;
    case (ins[6:0])
      7'b0110011: res = aluRef(f3, ins[30], regs[ins[19:15]], regs[ins[24:20]]);
      // only the shift right uses bit 30 as an operation bit
      7'b0010011: res = aluRef(f3, ins[30] && (f3 == 3'd5), regs[ins[19:15]], immI);
      7'b0110111: res = {ins[31:12], 12'b0};
      7'b0010111: res = pc + {ins[31:12], 12'b0};
      7'b0000011: begin
        addr = regs[ins[19:15]] + immI;
        w    = mem[addr[7:2]];
        case (f3)
          3'd0: res = {{24{w[7]}}, w[7:0]};
          3'd1: res = {{16{w[15]}}, w[15:0]};
          3'd4: res = {24'b0, w[7:0]};
          3'd5: res = {16'b0, w[15:0]};
          default: res = w;
        endcase
      end
      7'b0100011: begin
        wr   = 1'b0;
        addr = regs[ins[19:15]] + immS;
        case (f3)
          3'd0: be = 4'b0001;
          3'd1: be = 4'b0011;
          default: be = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
          if (be[b]) begin
            mem[addr[7:2]][8*b +: 8] = regs[ins[24:20]][8*b +: 8];
          end
        end
        expAddr.push_back({addr[31:2], 2'b00});
        expData.push_back(regs[ins[24:20]]);
        expBe.push_back(be);
      end
      default: wr = 1'b0;
    endcase
    if (wr && (ins[11:7] != 5'd0)) begin
      regs[ins[11:7]] = res;
    end
  end
endfunction

`endif

// File: tests/rvCoreTb.sv
`timescale 1ns/10ps

module rvCoreTb;

  localparam rvCorePkg::word_t resetPc = 32'h0000_0200;
  localparam int progLen = 200;
  localparam int timeoutCycles = 20000;
  localparam rvCorePkg::word_t nop = 32'h0000_0013;

  // one data bus request as seen by the memory
  typedef struct packed {
    logic               read;
    logic               we;
    rvCorePkg::word_t   addr;
    rvCorePkg::word_t   data;
    rvCorePkg::byteEn_t be;
  } dbusReq_t;

  logic clk = 1'b0;
  logic rst_n;
  rvCorePkg::word_t ibusAddr;
  logic ibusRead;
  rvCorePkg::word_t ibusData;
  rvCorePkg::word_t ibusIAddr;
  logic ibusValid;
  logic ibusWait;
  rvCorePkg::word_t dbusAddr;
  rvCorePkg::word_t dbusData;
  logic dbusRead;
  logic dbusWe;
  rvCorePkg::byteEn_t dbusByteEn;
  rvCorePkg::word_t dbusRdata;
  logic dbusWait;

  integer seed;
  rvCorePkg::word_t imem [512];
  rvCorePkg::word_t dmem [64];
  // expected stores in program order
  rvCorePkg::word_t expAddr [$];
  rvCorePkg::word_t expData [$];
  rvCorePkg::byteEn_t expBe [$];
  int storeIdx;
  // instruction read taken at the coming edge
  logic taken;
  rvCorePkg::word_t takenAddr;
  // data access state
  logic busy;
  int waitLeft;
  logic holding;
  dbusReq_t held;
  dbusReq_t req;
  int cycles;

`include "rvRefModel.svh"

  rvCore #(
    .resetPc (resetPc)
  ) u_rvCore (
    .clk        (clk),
    .rst_n      (rst_n),
    .ibusAddr   (ibusAddr),
    .ibusRead   (ibusRead),
    .ibusData   (ibusData),
    .ibusIAddr  (ibusIAddr),
    .ibusValid  (ibusValid),
    .ibusWait   (ibusWait),
    .dbusAddr   (dbusAddr),
    .dbusData   (dbusData),
    .dbusRead   (dbusRead),
    .dbusWe     (dbusWe),
    .dbusByteEn (dbusByteEn),
    .dbusRdata  (dbusRdata),
    .dbusWait   (dbusWait)
  );

  // ======================================================================
  // helpers
  // ======================================================================

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic rvCorePkg::word_t laneMask(input rvCorePkg::byteEn_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic rvCorePkg::word_t encR(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rvCorePkg::word_t encI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rvCorePkg::word_t encS(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  task automatic failValue(input string sig, input rvCorePkg::word_t got,
                           input rvCorePkg::word_t exp);
    $display("ERROR time=%0t %s got=%h expected=%h", $time, sig, got, exp);
    $display("STATUS: FAIL");
    $fatal(1, "value mismatch on %s", sig);
  endtask

  task automatic failPlain(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "%s", msg);
  endtask

  // ======================================================================
  // program generation
  // ======================================================================

  task automatic buildProgram();
    int base;
    int kind;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] imm;
    logic alt;
    base = int'(resetPc[10:2]);
    for (int i = 0; i < 512; i++) begin
      imem[i] = nop;
    end
    // registers are not reset, so x1..x7 get values first
    for (int r = 1; r < 8; r++) begin
      imem[base + r - 1] = encI(12'(rnd(4096)), 5'd0, 3'd0, 5'(r), 7'b0010011);
    end
    for (int i = 7; i < progLen - 7; i++) begin
      kind = rnd(6);
      rd   = 5'(1 + rnd(7));
      rs1  = 5'(rnd(8));
      rs2  = 5'(rnd(8));
      f3   = 3'(rnd(8));
      alt  = (rnd(2) == 1);
      case (kind)
        0: begin
          imem[base + i] = encR(((f3 == 3'd0) || (f3 == 3'd5)) && alt ? 7'b0100000 : 7'b0,
                                rs2, rs1, f3, rd);
        end
        1: begin
          // shift amount sits in the rs2 field position
          if (f3 == 3'd1) begin
            imm = {7'b0, rs2};
          end else if (f3 == 3'd5) begin
            imm = {1'b0, alt, 5'b0, rs2};
          end else begin
            imm = 12'(rnd(4096));
          end
          imem[base + i] = encI(imm, rs1, f3, rd, 7'b0010011);
        end
        2: imem[base + i] = {20'(rnd(1 << 20)), rd, 7'b0110111};
        3: imem[base + i] = {20'(rnd(1 << 20)), rd, 7'b0010111};
        4: begin
          case (rnd(5))
            0: f3 = 3'd0;
            1: f3 = 3'd1;
            2: f3 = 3'd2;
            3: f3 = 3'd4;
            default: f3 = 3'd5;
          endcase
          // x0 plus a word offset inside the data region
          imm = {4'b0, 6'(rnd(64)), 2'b00};
          imem[base + i] = encI(imm, 5'd0, f3, rd, 7'b0000011);
        end
        default: begin
          imm = {4'b0, 6'(rnd(64)), 2'b00};
          imem[base + i] = encS(imm, rs2, 5'd0, 3'(rnd(3)));
        end
      endcase
    end
    // dump every register to memory at the end
    for (int r = 1; r < 8; r++) begin
      imem[base + progLen - 8 + r] = encS(12'((r - 1) * 4), 5'(r), 5'd0, 3'd2);
    end
  endtask

  // ======================================================================
  // store check
  // ======================================================================

  task automatic checkStore(input dbusReq_t s);
    rvCorePkg::word_t m;
    assert (storeIdx < expAddr.size())
      else failPlain("a store appeared after the last expected store");
    m = laneMask(expBe[storeIdx]);
    assert (s.addr == expAddr[storeIdx])
      else failValue("dbusAddr", s.addr, expAddr[storeIdx]);
    assert (s.be == expBe[storeIdx])
      else failValue("dbusByteEn", 32'(s.be), 32'(expBe[storeIdx]));
    assert ((s.data & m) == (expData[storeIdx] & m))
      else failValue("dbusData", s.data & m, expData[storeIdx] & m);
    for (int b = 0; b < 4; b++) begin
      if (s.be[b]) begin
        dmem[s.addr[7:2]][8*b +: 8] = s.data[8*b +: 8];
      end
    end
    storeIdx++;
  endtask

  // ======================================================================
  // clock, memories and run control
  // ======================================================================

  initial begin
    forever #2 clk = ~clk;
  end

  // bus models drive on the falling edge and sample 1 ns later when settled
  initial begin
    forever begin
      @(negedge clk);
      // instruction word for the read taken one cycle ago
      ibusValid = taken;
      ibusIAddr = takenAddr;
      ibusData  = imem[takenAddr[10:2]];
      ibusWait  = (rnd(4) == 0);
      if (dbusRead || dbusWe) begin
        if (!busy) begin
          busy     = 1'b1;
          waitLeft = rnd(4);
        end
        dbusWait = (waitLeft != 0);
        if (waitLeft != 0) begin
          waitLeft--;
        end
        dbusRdata = dmem[dbusAddr[7:2]];
      end else begin
        dbusWait = 1'b0;
      end
      #1;
      taken     = ibusRead && !ibusWait;
      takenAddr = ibusAddr;
      req       = {dbusRead, dbusWe, dbusAddr, dbusData, dbusByteEn};
      if (req.read || req.we) begin
        if (holding) begin
          assert (req === held)
            else failPlain("the data bus request changed while dbusWait was high");
        end
        if (dbusWait) begin
          held    = req;
          holding = 1'b1;
        end else begin
          holding = 1'b0;
          busy    = 1'b0;
          if (req.we) begin
            checkStore(req);
          end
        end
      end
    end
  end

  initial begin
    seed       = 32'hf12;
    rst_n      = 1'b0;
    ibusData   = '0;
    ibusIAddr  = '0;
    ibusValid  = 1'b0;
    ibusWait   = 1'b0;
    dbusRdata  = '0;
    dbusWait   = 1'b0;
    taken      = 1'b0;
    takenAddr  = '0;
    busy       = 1'b0;
    waitLeft   = 0;
    holding    = 1'b0;
    held       = '0;
    storeIdx   = 0;
    for (int k = 0; k < 64; k++) begin
      dmem[k] = fillWord(k);
    end
    buildProgram();
    runReference();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // run until every expected store was seen
    cycles = 0;
    while ((storeIdx < expAddr.size()) && (cycles < timeoutCycles)) begin
      @(posedge clk);
      cycles++;
    end
    if (storeIdx == expAddr.size()) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "timed out after %0d cycles with %0d of %0d stores seen",
             cycles, storeIdx, expAddr.size());
    end
  end

endmodule

// File: build.f
verilog/rvCorePkg.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/operandStage.sv
verilog/executeStage.sv
verilog/rvCore.sv
+incdir+tests
tests/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    -f build.f \
    --top-module rvCoreTb \
    -Mdir obj_dir \
    -o simv; then
  echo "compile failed"
  exit 1
fi

if ! ./obj_dir/simv; then
  echo "simulation failed"
  exit 1
fi

echo "simulation finished"
exit 0
